// ==== store_queue.f ====
+incdir+src
src/sq_pkg.sv
src/sq_ring_ctrl.sv
src/sq_entry_array.sv
src/sq_drain.sv
src/store_queue.sv
sim/store_queue_props.sv
sim/store_queue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the store queue testbench with verilator and run it
# the run counts as failed when the log holds the fail line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f store_queue.f \
  --top-module store_queue_tb -o store_queue_sim > sim.log 2>&1 &&
  ./obj_dir/store_queue_sim >> sim.log 2>&1 ||
  echo "Simulation FAILED" >> sim.log

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
exit 0

// ==== sim/store_queue_tb.sv ====
`timescale 1ns/1ps
`include "sq_cfg.svh"

module store_queue_tb;

  import sq_pkg::*;

  localparam int       DEPTH       = `SQ_DEPTH;
  localparam int       REQ_TIMEOUT = 20;
  // rob head value that names no store
  localparam rob_idx_t ROB_IDLE    = 5'h1f;

  logic      clock = 1'b0;
  logic      reset;
  logic      enq_valid_i;
  mem_size_e enq_size_i;
  rob_idx_t  enq_rob_idx_i;
  logic      full_o;
  sq_cnt_t   free_slots_o;
  logic      data_valid_i;
  rob_idx_t  data_rob_idx_i;
  addr_t     data_addr_i;
  data_t     data_i;
  rob_idx_t  rob_head_i;
  logic      rob_store_ready_valid_o;
  rob_idx_t  rob_store_ready_idx_o;
  logic      dc_req_valid_o;
  addr_t     dc_req_addr_o;
  mem_size_e dc_req_size_o;
  data_t     dc_req_data_o;
  rob_idx_t  dc_req_rob_idx_o;
  logic      dc_req_accept_i;
  logic      dc_store_valid_i;
  rob_idx_t  dc_store_rob_idx_i;
  logic      restore_valid_i;
  sq_idx_t   restore_tail_i;

  integer    seed;
  // expected queue contents in age order
  sq_entry_t model_q[$];
  int        head_ptr;

  store_queue dut (.*);

  bind store_queue store_queue_props u_props (
    .clock                   (clock),
    .reset                   (reset),
    .full_o                  (full_o),
    .free_slots_o            (free_slots_o),
    .rob_store_ready_valid_o (rob_store_ready_valid_o),
    .dc_req_valid_o          (dc_req_valid_o),
    .dc_req_addr_o           (dc_req_addr_o),
    .dc_req_size_o           (dc_req_size_o),
    .dc_req_data_o           (dc_req_data_o),
    .dc_req_rob_idx_o        (dc_req_rob_idx_o),
    .dc_req_accept_i         (dc_req_accept_i)
  );

  always #50 clock = ~clock;

  // ==================================================
  // reporting and compares
  // ==================================================

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cnt(input sq_cnt_t got, input sq_cnt_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rob(input rob_idx_t got, input rob_idx_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // request fields against the oldest model entry
  task automatic check_req(input sq_entry_t exp);
    if (dc_req_addr_o !== exp.addr || dc_req_size_o !== exp.size ||
        dc_req_data_o !== exp.data || dc_req_rob_idx_o !== exp.rob_idx) begin
      $display("Mismatch at %0d ns: request rob %0d addr %h size %0d data %h",
               $time, dc_req_rob_idx_o, dc_req_addr_o, dc_req_size_o, dc_req_data_o);
      $display("  expected rob %0d addr %h size %0d data %h",
               exp.rob_idx, exp.addr, exp.size, exp.data);
      abort_run();
    end
  endtask

  // ==================================================
  // drivers
  // ==================================================

  task automatic next_cycle();
    @(negedge clock);
  endtask

  task automatic enqueue_store(input mem_size_e size, input rob_idx_t rob);
    sq_entry_t e;
    logic      room;
    e         = '0;
    e.valid   = 1'b1;
    e.size    = size;
    e.rob_idx = rob;
    room      = (model_q.size() < DEPTH);
    enq_valid_i   = 1'b1;
    enq_size_i    = size;
    enq_rob_idx_i = rob;
    next_cycle();
    enq_valid_i = 1'b0;
    // a full queue drops it silently
    if (room) begin
      model_q.push_back(e);
    end
    check_cnt(free_slots_o, sq_cnt_t'(DEPTH - model_q.size()), "free slots after enqueue");
    check_flag(full_o, model_q.size() == DEPTH, "full flag after enqueue");
  endtask

  task automatic deliver_data(input rob_idx_t rob, input addr_t addr, input data_t data);
    sq_entry_t e;
    data_valid_i   = 1'b1;
    data_rob_idx_i = rob;
    data_addr_i    = addr;
    data_i         = data;
    next_cycle();
    data_valid_i = 1'b0;
    // first live entry with this rob index takes it
    for (int i = 0; i < model_q.size(); i++) begin
      if (model_q[i].rob_idx == rob) begin
        e            = model_q[i];
        e.addr       = addr;
        e.data       = data;
        e.addr_valid = 1'b1;
        e.data_valid = 1'b1;
        model_q[i]   = e;
        break;
      end
    end
  endtask

  // point the rob head at a store and expect a report only if its data is in
  task automatic commit_store(input rob_idx_t rob);
    sq_entry_t e;
    int        hit;
    hit = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      if (hit < 0 && model_q[i].rob_idx == rob && model_q[i].data_valid) begin
        hit = i;
      end
    end
    rob_head_i = rob;
    next_cycle();
    rob_head_i = ROB_IDLE;
    check_flag(rob_store_ready_valid_o, hit >= 0, "rob ready valid");
    check_rob(rob_store_ready_idx_o, (hit >= 0) ? rob : '0, "rob ready index");
    if (hit >= 0) begin
      e           = model_q[hit];
      e.committed = 1'b1;
      model_q[hit] = e;
    end
  endtask

  task automatic restore_to(input int ahead);
    restore_valid_i = 1'b1;
    restore_tail_i  = sq_idx_t'((head_ptr + ahead) % DEPTH);
    next_cycle();
    restore_valid_i = 1'b0;
    while (model_q.size() > ahead) begin
      model_q.delete(model_q.size() - 1);
    end
    check_cnt(free_slots_o, sq_cnt_t'(DEPTH - ahead), "free slots after restore");
  endtask

  // ==================================================
  // cache side
  // ==================================================

  task automatic expect_no_request(input int cycles, input string what);
    repeat (cycles) begin
      next_cycle();
      check_flag(dc_req_valid_o, 1'b0, what);
    end
  endtask

  task automatic wait_request();
    int n;
    n = 0;
    while (!dc_req_valid_o && n < REQ_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!dc_req_valid_o) begin
      $display("timed out waiting for a data cache request at %0d ns", $time);
      abort_run();
    end
  endtask

  // drain one store with accept delayed by hold cycles and an optional stray completion
  task automatic drain_store(input int hold, input logic stray, input rob_idx_t stray_rob);
    sq_entry_t exp;
    if (model_q.size() == 0) begin
      $display("no store left in the model to drain at %0d ns", $time);
      abort_run();
    end
    exp = model_q[0];
    wait_request();
    check_req(exp);
    repeat (hold) begin
      next_cycle();
      check_flag(dc_req_valid_o, 1'b1, "request under back-pressure");
      check_req(exp);
    end
    dc_req_accept_i = 1'b1;
    next_cycle();
    dc_req_accept_i = 1'b0;
    check_flag(dc_req_valid_o, 1'b0, "request after accept");
    expect_no_request(3, "request while a store is outstanding");
    if (stray) begin
      dc_store_valid_i   = 1'b1;
      dc_store_rob_idx_i = stray_rob;
      next_cycle();
      dc_store_valid_i = 1'b0;
      check_flag(dc_req_valid_o, 1'b0, "request after stray completion");
      check_cnt(free_slots_o, sq_cnt_t'(DEPTH - model_q.size()), "free slots after stray");
    end
    dc_store_valid_i   = 1'b1;
    dc_store_rob_idx_i = exp.rob_idx;
    next_cycle();
    dc_store_valid_i = 1'b0;
    model_q.delete(0);
    head_ptr = (head_ptr + 1) % DEPTH;
    check_cnt(free_slots_o, sq_cnt_t'(DEPTH - model_q.size()), "free slots after completion");
    check_flag(full_o, 1'b0, "full flag after completion");
  endtask

  // ==================================================
  // directed tests
  // ==================================================

  task automatic test_reset_state();
    check_cnt(free_slots_o, sq_cnt_t'(DEPTH), "free slots after reset");
    check_flag(full_o, 1'b0, "full flag after reset");
    check_flag(dc_req_valid_o, 1'b0, "request after reset");
    check_flag(rob_store_ready_valid_o, 1'b0, "rob ready after reset");
  endtask

  task automatic test_fill_and_drain();
    addr_t a;
    data_t d;
    for (int i = 0; i < DEPTH; i++) begin
      enqueue_store(mem_size_e'(i % 4), rob_idx_t'(i));
    end
    // one more while full
    enqueue_store(DOUBLE, rob_idx_t'(DEPTH));
    for (int i = 0; i < DEPTH; i++) begin
      a = $random(seed);
      d = {$random(seed), $random(seed)};
      deliver_data(rob_idx_t'(i), a, d);
    end
    for (int i = 0; i < DEPTH; i++) begin
      commit_store(rob_idx_t'(i));
    end
    for (int i = 0; i < DEPTH; i++) begin
      drain_store(0, 1'b0, '0);
    end
  endtask

  task automatic test_out_of_order_data();
    rob_idx_t  order [4] = '{5'd12, 5'd10, 5'd13, 5'd11};
    mem_size_e sizes [4] = '{BYTE, WORD, HALF, DOUBLE};
    addr_t     a;
    data_t     d;
    for (int i = 0; i < 4; i++) begin
      enqueue_store(sizes[i], rob_idx_t'(10 + i));
    end
    foreach (order[i]) begin
      a = $random(seed);
      d = {$random(seed), $random(seed)};
      deliver_data(order[i], a, d);
    end
    // data present but no commit yet
    expect_no_request(4, "request before commit");
    for (int i = 0; i < 4; i++) begin
      commit_store(rob_idx_t'(10 + i));
    end
    for (int i = 0; i < 4; i++) begin
      drain_store(0, 1'b0, '0);
    end
  endtask

  task automatic test_back_pressure();
    enqueue_store(WORD, 5'd20);
    enqueue_store(HALF, 5'd21);
    deliver_data(5'd20, $random(seed), {$random(seed), $random(seed)});
    deliver_data(5'd21, $random(seed), {$random(seed), $random(seed)});
    commit_store(5'd20);
    commit_store(5'd21);
    // stray completion names the younger store
    drain_store(4, 1'b1, 5'd21);
    drain_store(0, 1'b0, '0);
  endtask

  task automatic test_restore();
    for (int i = 0; i < 5; i++) begin
      enqueue_store(mem_size_e'(i % 4), rob_idx_t'(24 + i));
    end
    restore_to(2);
    enqueue_store(DOUBLE, 5'd29);
    // rob 26 was squashed so its data finds nothing
    deliver_data(5'd26, $random(seed), {$random(seed), $random(seed)});
    deliver_data(5'd24, $random(seed), {$random(seed), $random(seed)});
    deliver_data(5'd25, $random(seed), {$random(seed), $random(seed)});
    deliver_data(5'd29, $random(seed), {$random(seed), $random(seed)});
    commit_store(5'd26);
    commit_store(5'd24);
    commit_store(5'd25);
    commit_store(5'd29);
    for (int i = 0; i < 3; i++) begin
      drain_store(0, 1'b0, '0);
    end
    expect_no_request(5, "request after restored stores drained");
    check_cnt(free_slots_o, sq_cnt_t'(DEPTH), "free slots at end of restore test");
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    seed               = 97;
    head_ptr           = 0;
    reset              = 1'b1;
    enq_valid_i        = 1'b0;
    enq_size_i         = BYTE;
    enq_rob_idx_i      = '0;
    data_valid_i       = 1'b0;
    data_rob_idx_i     = '0;
    data_addr_i        = '0;
    data_i             = '0;
    rob_head_i         = ROB_IDLE;
    dc_req_accept_i    = 1'b0;
    dc_store_valid_i   = 1'b0;
    dc_store_rob_idx_i = '0;
    restore_valid_i    = 1'b0;
    restore_tail_i     = '0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_fill_and_drain();
    test_out_of_order_data();
    test_back_pressure();
    test_restore();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== sim/store_queue_props.sv ====
`timescale 1ns/1ps

module store_queue_props (
  input logic              clock,
  input logic              reset,
  input logic              full_o,
  input sq_pkg::sq_cnt_t   free_slots_o,
  input logic              rob_store_ready_valid_o,
  input logic              dc_req_valid_o,
  input sq_pkg::addr_t     dc_req_addr_o,
  input sq_pkg::mem_size_e dc_req_size_o,
  input sq_pkg::data_t     dc_req_data_o,
  input sq_pkg::rob_idx_t  dc_req_rob_idx_o,
  input logic              dc_req_accept_i
);

  import sq_pkg::*;

  // ==================================================
  // cache request handshake
  // ==================================================

  // pending request keeps valid and every field
  a_req_holds: assert property (@(posedge clock) disable iff (reset)
    (dc_req_valid_o && !dc_req_accept_i) |=>
      (dc_req_valid_o && $stable(dc_req_addr_o) && $stable(dc_req_size_o) &&
       $stable(dc_req_data_o) && $stable(dc_req_rob_idx_o)))
    else $error("cache request changed before it was accepted");

  // ==================================================
  // status and reset
  // ==================================================

  // full leaves no free slot and is only reached from the last one
  a_full_no_free: assert property (@(posedge clock) disable iff (reset)
    full_o |-> ((free_slots_o == '0) &&
                ($past(full_o) || ($past(free_slots_o) == sq_cnt_t'(1)))))
    else $error("full flag raised without filling the last free slot");

  // nothing leaves the queue while reset is applied
  a_quiet_in_reset: assert property (@(posedge clock)
    reset |=> (!dc_req_valid_o && !rob_store_ready_valid_o))
    else $error("request or ready pulse seen during reset");

endmodule

// ==== src/store_queue.sv ====
`timescale 1ns/1ps

module store_queue (
  input  logic              clock,
  input  logic              reset,
  // dispatch
  input  logic              enq_valid_i,
  input  sq_pkg::mem_size_e enq_size_i,
  input  sq_pkg::rob_idx_t  enq_rob_idx_i,
  output logic              full_o,
  output sq_pkg::sq_cnt_t   free_slots_o,
  // address and data from execute
  input  logic              data_valid_i,
  input  sq_pkg::rob_idx_t  data_rob_idx_i,
  input  sq_pkg::addr_t     data_addr_i,
  input  sq_pkg::data_t     data_i,
  // rob
  input  sq_pkg::rob_idx_t  rob_head_i,
  output logic              rob_store_ready_valid_o,
  output sq_pkg::rob_idx_t  rob_store_ready_idx_o,
  // data cache request
  output logic              dc_req_valid_o,
  output sq_pkg::addr_t     dc_req_addr_o,
  output sq_pkg::mem_size_e dc_req_size_o,
  output sq_pkg::data_t     dc_req_data_o,
  output sq_pkg::rob_idx_t  dc_req_rob_idx_o,
  input  logic              dc_req_accept_i,
  // data cache completion
  input  logic              dc_store_valid_i,
  input  sq_pkg::rob_idx_t  dc_store_rob_idx_i,
  // mispredict restore
  input  logic              restore_valid_i,
  input  sq_pkg::sq_idx_t   restore_tail_i
);

  import sq_pkg::*;

  logic      enq_write;
  logic      retire;
  sq_idx_t   head;
  sq_idx_t   tail;
  sq_entry_t head_entry;

  // ==================================================
  // pointers and occupancy
  // ==================================================

  sq_ring_ctrl u_ring (
    .clock           (clock),
    .reset           (reset),
    .enq_valid_i     (enq_valid_i),
    .retire_i        (retire),
    .restore_valid_i (restore_valid_i),
    .restore_tail_i  (restore_tail_i),
    .enq_write_o     (enq_write),
    .head_o          (head),
    .tail_o          (tail),
    .full_o          (full_o),
    .free_slots_o    (free_slots_o)
  );

  // entry storage and rob matching
  sq_entry_array u_entries (
    .clock                   (clock),
    .reset                   (reset),
    .enq_write_i             (enq_write),
    .tail_i                  (tail),
    .head_i                  (head),
    .enq_size_i              (enq_size_i),
    .enq_rob_idx_i           (enq_rob_idx_i),
    .data_valid_i            (data_valid_i),
    .data_rob_idx_i          (data_rob_idx_i),
    .data_addr_i             (data_addr_i),
    .data_i                  (data_i),
    .rob_head_i              (rob_head_i),
    .restore_valid_i         (restore_valid_i),
    .restore_tail_i          (restore_tail_i),
    .retire_i                (retire),
    .head_entry_o            (head_entry),
    .rob_store_ready_valid_o (rob_store_ready_valid_o),
    .rob_store_ready_idx_o   (rob_store_ready_idx_o)
  );

  // head store out to the cache
  sq_drain u_drain (
    .clock              (clock),
    .reset              (reset),
    .head_entry_i       (head_entry),
    .dc_req_accept_i    (dc_req_accept_i),
    .dc_store_valid_i   (dc_store_valid_i),
    .dc_store_rob_idx_i (dc_store_rob_idx_i),
    .dc_req_valid_o     (dc_req_valid_o),
    .dc_req_addr_o      (dc_req_addr_o),
    .dc_req_size_o      (dc_req_size_o),
    .dc_req_data_o      (dc_req_data_o),
    .dc_req_rob_idx_o   (dc_req_rob_idx_o),
    .retire_o           (retire)
  );

endmodule

// ==== src/sq_drain.sv ====
`timescale 1ns/1ps

module sq_drain (
  input  logic              clock,
  input  logic              reset,
  input  sq_pkg::sq_entry_t head_entry_i,
  input  logic              dc_req_accept_i,
  input  logic              dc_store_valid_i,
  input  sq_pkg::rob_idx_t  dc_store_rob_idx_i,
  output logic              dc_req_valid_o,
  output sq_pkg::addr_t     dc_req_addr_o,
  output sq_pkg::mem_size_e dc_req_size_o,
  output sq_pkg::data_t     dc_req_data_o,
  output sq_pkg::rob_idx_t  dc_req_rob_idx_o,
  output logic              retire_o
);

  import sq_pkg::*;

  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_REQ,
    DRAIN_WAIT
  } drain_state_e;

  drain_state_e state_q;
  logic         head_ready;

  // request fields held under back-pressure
  addr_t     req_addr_q;
  mem_size_e req_size_q;
  data_t     req_data_q;
  rob_idx_t  req_rob_q;

  // head store may leave once committed with address and data in
  assign head_ready = head_entry_i.valid && head_entry_i.committed &&
                      head_entry_i.addr_valid && head_entry_i.data_valid;

  // completion for the one outstanding store
  assign retire_o = (state_q == DRAIN_WAIT) && dc_store_valid_i &&
                    (dc_store_rob_idx_i == req_rob_q);

  assign dc_req_valid_o   = (state_q == DRAIN_REQ);
  assign dc_req_addr_o    = req_addr_q;
  assign dc_req_size_o    = req_size_q;
  assign dc_req_data_o    = req_data_q;
  assign dc_req_rob_idx_o = req_rob_q;

  // ==================================================
  // issue FSM
  // ==================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= DRAIN_IDLE;
    end else begin
      case (state_q)
        DRAIN_IDLE: begin
          if (head_ready) begin
            state_q <= DRAIN_REQ;
          end
        end
        DRAIN_REQ: begin
          if (dc_req_accept_i) begin
            state_q <= DRAIN_WAIT;
          end
        end
        DRAIN_WAIT: begin
          if (retire_o) begin
            state_q <= DRAIN_IDLE;
          end
        end
        default: begin
          state_q <= DRAIN_IDLE;
        end
      endcase
    end
  end

  // latch head store only when leaving idle
  always_ff @(posedge clock) begin
    if ((state_q == DRAIN_IDLE) && head_ready) begin
      req_addr_q <= head_entry_i.addr;
      req_size_q <= head_entry_i.size;
      req_data_q <= head_entry_i.data;
      req_rob_q  <= head_entry_i.rob_idx;
    end
  end

endmodule

// ==== src/sq_entry_array.sv ====
`timescale 1ns/1ps
`include "sq_cfg.svh"

module sq_entry_array (
  input  logic              clock,
  input  logic              reset,
  input  logic              enq_write_i,
  input  sq_pkg::sq_idx_t   tail_i,
  input  sq_pkg::sq_idx_t   head_i,
  input  sq_pkg::mem_size_e enq_size_i,
  input  sq_pkg::rob_idx_t  enq_rob_idx_i,
  input  logic              data_valid_i,
  input  sq_pkg::rob_idx_t  data_rob_idx_i,
  input  sq_pkg::addr_t     data_addr_i,
  input  sq_pkg::data_t     data_i,
  input  sq_pkg::rob_idx_t  rob_head_i,
  input  logic              restore_valid_i,
  input  sq_pkg::sq_idx_t   restore_tail_i,
  input  logic              retire_i,
  output sq_pkg::sq_entry_t head_entry_o,
  output logic              rob_store_ready_valid_o,
  output sq_pkg::rob_idx_t  rob_store_ready_idx_o
);

  import sq_pkg::*;

  // ==================================================
  // storage
  // ==================================================

  // per-entry control flags
  logic valid_q      [`SQ_DEPTH];
  logic addr_valid_q [`SQ_DEPTH];
  logic data_valid_q [`SQ_DEPTH];
  logic committed_q  [`SQ_DEPTH];

  // per-entry payload
  addr_t     addr_q [`SQ_DEPTH];
  mem_size_e size_q [`SQ_DEPTH];
  rob_idx_t  rob_q  [`SQ_DEPTH];
  data_t     data_q [`SQ_DEPTH];

  // search results
  logic     data_hit;
  sq_idx_t  data_sel;
  logic     commit_hit;
  sq_idx_t  commit_sel;
  rob_idx_t commit_rob;

  // true when i lies in [head, tail) on the ring
  function automatic logic in_ring(input sq_idx_t i, input sq_idx_t h, input sq_idx_t t);
    if (h <= t) begin
      return (i >= h) && (i < t);
    end
    return (i >= h) || (i < t);
  endfunction

  // ==================================================
  // rob index searches
  // ==================================================

  // lowest valid entry waiting on this rob index
  always_comb begin
    data_hit = 1'b0;
    data_sel = '0;
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      if (!data_hit && valid_q[i] && (rob_q[i] == data_rob_idx_i)) begin
        data_hit = 1'b1;
        data_sel = sq_idx_t'(i);
      end
    end
  end

  // rob head names a store whose data is in
  always_comb begin
    commit_hit = 1'b0;
    commit_sel = '0;
    commit_rob = '0;
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      if (!commit_hit && valid_q[i] && data_valid_q[i] && (rob_q[i] == rob_head_i)) begin
        commit_hit = 1'b1;
        commit_sel = sq_idx_t'(i);
        commit_rob = rob_q[i];
      end
    end
  end

  // ==================================================
  // flag updates
  // ==================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
        valid_q[i]      <= 1'b0;
        addr_valid_q[i] <= 1'b0;
        data_valid_q[i] <= 1'b0;
        committed_q[i]  <= 1'b0;
      end
    end else begin
      if (restore_valid_i) begin
        // drop everything younger than the restore tail
        for (int i = 0; i < `SQ_DEPTH; i++) begin
          if (!in_ring(sq_idx_t'(i), head_i, restore_tail_i)) begin
            valid_q[i]      <= 1'b0;
            addr_valid_q[i] <= 1'b0;
            data_valid_q[i] <= 1'b0;
            committed_q[i]  <= 1'b0;
          end
        end
      end else begin
        // fresh slot, nothing known yet
        if (enq_write_i) begin
          valid_q[tail_i]      <= 1'b1;
          addr_valid_q[tail_i] <= 1'b0;
          data_valid_q[tail_i] <= 1'b0;
          committed_q[tail_i]  <= 1'b0;
        end
        if (data_valid_i && data_hit) begin
          addr_valid_q[data_sel] <= 1'b1;
          data_valid_q[data_sel] <= 1'b1;
        end
        if (commit_hit) begin
          committed_q[commit_sel] <= 1'b1;
        end
      end
      // completed store leaves from the head
      if (retire_i) begin
        valid_q[head_i]      <= 1'b0;
        addr_valid_q[head_i] <= 1'b0;
        data_valid_q[head_i] <= 1'b0;
        committed_q[head_i]  <= 1'b0;
      end
    end
  end

  // ==================================================
  // payload writes
  // ==================================================

  always_ff @(posedge clock) begin
    if (!restore_valid_i) begin
      if (enq_write_i) begin
        addr_q[tail_i] <= '0;
        size_q[tail_i] <= enq_size_i;
        rob_q[tail_i]  <= enq_rob_idx_i;
        data_q[tail_i] <= '0;
      end
      if (data_valid_i && data_hit) begin
        addr_q[data_sel] <= data_addr_i;
        data_q[data_sel] <= data_i;
      end
    end
  end

  // commit report, one cycle after the match
  always_ff @(posedge clock) begin
    if (reset) begin
      rob_store_ready_valid_o <= 1'b0;
      rob_store_ready_idx_o   <= '0;
    end else if (!restore_valid_i && commit_hit) begin
      rob_store_ready_valid_o <= 1'b1;
      rob_store_ready_idx_o   <= commit_rob;
    end else begin
      rob_store_ready_valid_o <= 1'b0;
      rob_store_ready_idx_o   <= '0;
    end
  end

  // head slot for the drain
  always_comb begin
    head_entry_o.valid      = valid_q[head_i];
    head_entry_o.addr_valid = addr_valid_q[head_i];
    head_entry_o.data_valid = data_valid_q[head_i];
    head_entry_o.committed  = committed_q[head_i];
    head_entry_o.addr       = addr_q[head_i];
    head_entry_o.size       = size_q[head_i];
    head_entry_o.rob_idx    = rob_q[head_i];
    head_entry_o.data       = data_q[head_i];
  end

endmodule

// ==== src/sq_ring_ctrl.sv ====
`timescale 1ns/1ps
`include "sq_cfg.svh"

module sq_ring_ctrl (
  input  logic            clock,
  input  logic            reset,
  input  logic            enq_valid_i,
  input  logic            retire_i,
  input  logic            restore_valid_i,
  input  sq_pkg::sq_idx_t restore_tail_i,
  output logic            enq_write_o,
  output sq_pkg::sq_idx_t head_o,
  output sq_pkg::sq_idx_t tail_o,
  output logic            full_o,
  output sq_pkg::sq_cnt_t free_slots_o
);

  import sq_pkg::*;

  sq_idx_t head_q;
  sq_idx_t tail_q;
  sq_cnt_t count_q;
  sq_cnt_t restore_cnt;

  // circular increment, wraps at depth-1
  function automatic sq_idx_t next_idx(input sq_idx_t p);
    if (p == sq_idx_t'(`SQ_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // entries from head up to (not incl) tail
  function automatic sq_cnt_t ring_dist(input sq_idx_t from, input sq_idx_t to);
    int d;
    d = int'(to) - int'(from);
    if (d < 0) begin
      d = d + `SQ_DEPTH;
    end
    return sq_cnt_t'(d);
  endfunction

  // ==================================================
  // status
  // ==================================================

  assign full_o       = (count_q == sq_cnt_t'(`SQ_DEPTH));
  assign free_slots_o = sq_cnt_t'(`SQ_DEPTH) - count_q;

  // enqueue only with room, never in a restore cycle
  assign enq_write_o = enq_valid_i && !full_o && !restore_valid_i;

  assign head_o = head_q;
  assign tail_o = tail_q;

  // occupancy after restore
  // a retire in the same cycle still removes the head store
  always_comb begin
    restore_cnt = ring_dist(head_q, restore_tail_i);
    if (retire_i && (restore_cnt != '0)) begin
      restore_cnt = restore_cnt - 1'b1;
    end
  end

  // ==================================================
  // pointers and count
  // ==================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      // drain side runs regardless of restore
      if (retire_i) begin
        head_q <= next_idx(head_q);
      end
      if (restore_valid_i) begin
        // roll tail back, younger stores drop out
        tail_q  <= restore_tail_i;
        count_q <= restore_cnt;
      end else begin
        if (enq_write_o) begin
          tail_q <= next_idx(tail_q);
        end
        case ({enq_write_o, retire_i})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

endmodule

// ==== src/sq_pkg.sv ====
`include "sq_cfg.svh"

package sq_pkg;

  // ==================================================
  // queue bookkeeping types
  // ==================================================

  // entry index, 0 .. depth-1
  typedef logic [$clog2(`SQ_DEPTH)-1:0] sq_idx_t;

  // occupancy / free count, 0 .. depth
  typedef logic [$clog2(`SQ_DEPTH+1)-1:0] sq_cnt_t;

  // ==================================================
  // payload words
  // ==================================================

  typedef logic [`SQ_ADDR_W-1:0] addr_t;
  typedef logic [`SQ_DATA_W-1:0] data_t;
  typedef logic [`SQ_ROB_IDX_W-1:0] rob_idx_t;

  // store size, bytes = 1 << size
  typedef enum logic [1:0] {
    BYTE   = 2'h0,
    HALF   = 2'h1,
    WORD   = 2'h2,
    DOUBLE = 2'h3
  } mem_size_e;

  // one queue slot
  // flags first, then address side, then data
  typedef struct packed {
    logic      valid;
    logic      addr_valid;
    logic      data_valid;
    logic      committed;
    addr_t     addr;
    mem_size_e size;
    rob_idx_t  rob_idx;
    data_t     data;
  } sq_entry_t;

endpackage

// ==== src/sq_cfg.svh ====
`ifndef SQ_CFG_SVH
`define SQ_CFG_SVH

// ==================================================
// store queue sizing
// ==================================================

// number of queue entries
// ring math holds for any depth of 2 or more
`define SQ_DEPTH 8

// ==================================================
// field widths
// ==================================================

// byte address of a store
`define SQ_ADDR_W 32

// one double word of store data
`define SQ_DATA_W 64

// rob index carried with each store
`define SQ_ROB_IDX_W 5

`endif
